/* logic/mem_sys_pkg.sv */
/*
  shared widths, cache geometry and address split for the memory side
  state enums for the cache fill FSMs and the bus arbiter
*/
package mem_sys_pkg;

  // data and address width of every port
  localparam int word_w = 32;

  // one word per line, so bits 1:0 only select a byte
  localparam int word_off_w = 2;

  // instruction cache geometry
  localparam int icache_lines = 8;
  localparam int icache_idx_w = 3;
  // tag covers everything above index and byte offset
  localparam int icache_tag_w = word_w - icache_idx_w - word_off_w;

  // data cache geometry
  localparam int dcache_lines = 8;
  localparam int dcache_idx_w = 3;
  localparam int dcache_tag_w = word_w - dcache_idx_w - word_off_w;

  // cache side FSM
  // idle serves hits, fill waits on the controller
  typedef enum logic {
    idle,
    fill
  } cache_state_t;

  // memory controller grant
  // one cycle in arb_idle between any two grants
  typedef enum logic [1:0] {
    arb_idle,
    serve_i,
    serve_d
  } arb_state_t;

endpackage

/* logic/icache.sv */
/*
  direct-mapped read-only instruction cache, one word per line
  fill FSM toward the memory controller, halt gate on fetches
*/
module icache (
  input  logic                           CLK,
  input  logic                           nRST,
  input  logic                           halt,
  input  logic [mem_sys_pkg::word_w-1:0] i_addr,
  input  logic                           i_ren,
  input  logic [mem_sys_pkg::word_w-1:0] ic_rdata,
  input  logic                           ic_busy,
  output logic [mem_sys_pkg::word_w-1:0] i_rdata,
  output logic                           i_busy,
  output logic [mem_sys_pkg::word_w-1:0] ic_addr,
  output logic                           ic_ren
);

  // address split
  logic [mem_sys_pkg::icache_idx_w-1:0] idx;
  logic [mem_sys_pkg::icache_tag_w-1:0] tag;

  // line storage
  logic [mem_sys_pkg::icache_tag_w-1:0] tag_arr  [mem_sys_pkg::icache_lines];
  logic [mem_sys_pkg::word_w-1:0]       data_arr [mem_sys_pkg::icache_lines];
  logic [mem_sys_pkg::icache_lines-1:0] valid;

  logic hit;
  logic fill_done;
  mem_sys_pkg::cache_state_t state, state_nxt;

  assign idx = i_addr[mem_sys_pkg::icache_idx_w+mem_sys_pkg::word_off_w-1:mem_sys_pkg::word_off_w];
  assign tag = i_addr[mem_sys_pkg::word_w-1:mem_sys_pkg::icache_idx_w+mem_sys_pkg::word_off_w];

  assign hit = valid[idx] && (tag_arr[idx] == tag);
  // controller answered this cycle
  assign fill_done = (state == mem_sys_pkg::fill) && !ic_busy;

  // next state
  always_comb begin
    state_nxt = state;
    case (state)
      mem_sys_pkg::idle: begin
        // halted core starts no new misses
        if (i_ren && !hit && !halt) begin
          state_nxt = mem_sys_pkg::fill;
        end
      end
      mem_sys_pkg::fill: begin
        if (!ic_busy) begin
          state_nxt = mem_sys_pkg::idle;
        end
      end
      default: state_nxt = mem_sys_pkg::idle;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= mem_sys_pkg::idle;
    end else begin
      state <= state_nxt;
    end
  end

  // valid bits, cleared on reset and set by a finished fill
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid <= '0;
    end else if (fill_done) begin
      valid[idx] <= 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (fill_done) begin
      tag_arr[idx]  <= tag;
      data_arr[idx] <= ic_rdata;
    end
  end

  // miss port, word aligned
  // a fill already on the bus runs to completion even if halt rises
  assign ic_ren  = (state == mem_sys_pkg::fill);
  assign ic_addr = {i_addr[mem_sys_pkg::word_w-1:mem_sys_pkg::word_off_w],
                    {mem_sys_pkg::word_off_w{1'b0}}};

  // forward the fill word, else read the array
  assign i_rdata = fill_done ? ic_rdata : data_arr[idx];

  // zero latency on a hit, halt stalls every fetch
  assign i_busy = i_ren && (halt ||
                  !(((state == mem_sys_pkg::idle) && hit) || fill_done));

  // the fetch stage must hold its address for the whole fill
  ic_addr_stable: assert property (
    @(posedge CLK) disable iff (!nRST)
    (ic_ren && ic_busy) |=> (ic_ren && $stable(ic_addr))
  );

endmodule

/* logic/dcache.sv */
/*
  direct-mapped data cache, write-through and no-write-allocate
  read misses fill one word, every write goes out to memory
*/
module dcache (
  input  logic                           CLK,
  input  logic                           nRST,
  input  logic [mem_sys_pkg::word_w-1:0] d_addr,
  input  logic                           d_ren,
  input  logic                           d_wen,
  input  logic [mem_sys_pkg::word_w-1:0] d_wdata,
  input  logic [mem_sys_pkg::word_w-1:0] dc_rdata,
  input  logic                           dc_busy,
  output logic [mem_sys_pkg::word_w-1:0] d_rdata,
  output logic                           d_busy,
  output logic [mem_sys_pkg::word_w-1:0] dc_addr,
  output logic                           dc_ren,
  output logic                           dc_wen,
  output logic [mem_sys_pkg::word_w-1:0] dc_wdata
);

  // address split
  logic [mem_sys_pkg::dcache_idx_w-1:0] idx;
  logic [mem_sys_pkg::dcache_tag_w-1:0] tag;

  // line storage
  logic [mem_sys_pkg::dcache_tag_w-1:0] tag_arr  [mem_sys_pkg::dcache_lines];
  logic [mem_sys_pkg::word_w-1:0]       data_arr [mem_sys_pkg::dcache_lines];
  logic [mem_sys_pkg::dcache_lines-1:0] valid;

  logic hit;
  logic read_hit;
  logic xfer_done;
  logic fill_done;
  logic write_upd;
  mem_sys_pkg::cache_state_t state, state_nxt;

  assign idx = d_addr[mem_sys_pkg::dcache_idx_w+mem_sys_pkg::word_off_w-1:mem_sys_pkg::word_off_w];
  assign tag = d_addr[mem_sys_pkg::word_w-1:mem_sys_pkg::dcache_idx_w+mem_sys_pkg::word_off_w];

  assign hit      = valid[idx] && (tag_arr[idx] == tag);
  assign read_hit = (state == mem_sys_pkg::idle) && d_ren && hit;

  // fill state doubles as the write transfer state
  assign xfer_done = (state == mem_sys_pkg::fill) && !dc_busy;
  assign fill_done = xfer_done && d_ren;
  // write-through, refresh the word only when the line is present
  assign write_upd = xfer_done && d_wen && hit;

  always_comb begin
    state_nxt = state;
    case (state)
      mem_sys_pkg::idle: begin
        // read miss or any write needs the bus
        if ((d_ren && !hit) || d_wen) begin
          state_nxt = mem_sys_pkg::fill;
        end
      end
      mem_sys_pkg::fill: begin
        if (!dc_busy) begin
          state_nxt = mem_sys_pkg::idle;
        end
      end
      default: state_nxt = mem_sys_pkg::idle;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= mem_sys_pkg::idle;
    end else begin
      state <= state_nxt;
    end
  end

  // write misses leave valid untouched
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid <= '0;
    end else if (fill_done) begin
      valid[idx] <= 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (fill_done) begin
      tag_arr[idx]  <= tag;
      data_arr[idx] <= dc_rdata;
    end else if (write_upd) begin
      data_arr[idx] <= d_wdata;
    end
  end

  // memory side, request levels follow the held pipeline request
  assign dc_ren   = (state == mem_sys_pkg::fill) && d_ren;
  assign dc_wen   = (state == mem_sys_pkg::fill) && d_wen;
  assign dc_addr  = {d_addr[mem_sys_pkg::word_w-1:mem_sys_pkg::word_off_w],
                     {mem_sys_pkg::word_off_w{1'b0}}};
  assign dc_wdata = d_wdata;

  assign d_rdata = fill_done ? dc_rdata : data_arr[idx];

  // hits finish at once, writes wait for memory
  assign d_busy = (d_ren || d_wen) && !(read_hit || xfer_done);

  // memory stage issues one operation at a time
  d_req_onehot: assert property (
    @(posedge CLK) disable iff (!nRST)
    !(d_ren && d_wen)
  );

  dc_req_onehot: assert property (
    @(posedge CLK) disable iff (!nRST)
    !(dc_ren && dc_wen)
  );

endmodule

/* logic/memory_controller.sv */
/*
  arbiter merging icache and dcache misses onto one word bus
  fixed data-first priority, grant held until the bus drops busy
*/
module memory_controller (
  input  logic                           CLK,
  input  logic                           nRST,
  input  logic [mem_sys_pkg::word_w-1:0] ic_addr,
  input  logic                           ic_ren,
  input  logic [mem_sys_pkg::word_w-1:0] dc_addr,
  input  logic                           dc_ren,
  input  logic                           dc_wen,
  input  logic [mem_sys_pkg::word_w-1:0] dc_wdata,
  input  logic [mem_sys_pkg::word_w-1:0] bus_rdata,
  input  logic                           bus_busy,
  output logic [mem_sys_pkg::word_w-1:0] ic_rdata,
  output logic                           ic_busy,
  output logic [mem_sys_pkg::word_w-1:0] dc_rdata,
  output logic                           dc_busy,
  output logic [mem_sys_pkg::word_w-1:0] bus_addr,
  output logic                           bus_ren,
  output logic                           bus_wen,
  output logic [mem_sys_pkg::word_w-1:0] bus_wdata
);

  mem_sys_pkg::arb_state_t state, state_nxt;

  logic grant_i;
  logic grant_d;

  assign grant_i = (state == mem_sys_pkg::serve_i);
  assign grant_d = (state == mem_sys_pkg::serve_d);

  always_comb begin
    state_nxt = state;
    case (state)
      mem_sys_pkg::arb_idle: begin
        // data side wins a tie
        if (dc_ren || dc_wen) begin
          state_nxt = mem_sys_pkg::serve_d;
        end else if (ic_ren) begin
          state_nxt = mem_sys_pkg::serve_i;
        end
      end
      mem_sys_pkg::serve_i, mem_sys_pkg::serve_d: begin
        // transfer done, back to idle for one cycle
        if (!bus_busy) begin
          state_nxt = mem_sys_pkg::arb_idle;
        end
      end
      default: state_nxt = mem_sys_pkg::arb_idle;
    endcase
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= mem_sys_pkg::arb_idle;
    end else begin
      state <= state_nxt;
    end
  end

  // bus follows the granted side
  assign bus_addr  = grant_i ? ic_addr : dc_addr;
  assign bus_ren   = (grant_i && ic_ren) || (grant_d && dc_ren);
  assign bus_wen   = grant_d && dc_wen;
  // only the data side ever writes
  assign bus_wdata = dc_wdata;

  assign ic_rdata = bus_rdata;
  assign dc_rdata = bus_rdata;

  // granted side sees the bus busy, the other stalls on its own request
  assign ic_busy = grant_i ? bus_busy : ic_ren;
  assign dc_busy = grant_d ? bus_busy : (dc_ren || dc_wen);

  bus_req_onehot: assert property (
    @(posedge CLK) disable iff (!nRST)
    !(bus_ren && bus_wen)
  );

endmodule

/* logic/core_mem_top.sv */
/*
  memory side top level, icache and dcache behind one controller
  sticky halt latch set by a retired halt instruction
*/
module core_mem_top (
  input  logic                           CLK,
  input  logic                           nRST,
  input  logic                           halt_req,
  input  logic [mem_sys_pkg::word_w-1:0] i_addr,
  input  logic                           i_ren,
  input  logic [mem_sys_pkg::word_w-1:0] d_addr,
  input  logic                           d_ren,
  input  logic                           d_wen,
  input  logic [mem_sys_pkg::word_w-1:0] d_wdata,
  input  logic [mem_sys_pkg::word_w-1:0] bus_rdata,
  input  logic                           bus_busy,
  output logic                           halt,
  output logic [mem_sys_pkg::word_w-1:0] i_rdata,
  output logic                           i_busy,
  output logic [mem_sys_pkg::word_w-1:0] d_rdata,
  output logic                           d_busy,
  output logic [mem_sys_pkg::word_w-1:0] bus_addr,
  output logic                           bus_ren,
  output logic                           bus_wen,
  output logic [mem_sys_pkg::word_w-1:0] bus_wdata
);

  // icache miss port
  logic [mem_sys_pkg::word_w-1:0] ic_addr;
  logic                           ic_ren;
  logic [mem_sys_pkg::word_w-1:0] ic_rdata;
  logic                           ic_busy;

  // dcache miss and write port
  logic [mem_sys_pkg::word_w-1:0] dc_addr;
  logic                           dc_ren;
  logic                           dc_wen;
  logic [mem_sys_pkg::word_w-1:0] dc_wdata;
  logic [mem_sys_pkg::word_w-1:0] dc_rdata;
  logic                           dc_busy;

  // halt stays set until reset
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      halt <= 1'b0;
    end else if (halt_req) begin
      halt <= 1'b1;
    end
  end

  icache icache_inst (
    .CLK     (CLK),
    .nRST    (nRST),
    .halt    (halt),
    .i_addr  (i_addr),
    .i_ren   (i_ren),
    .ic_rdata(ic_rdata),
    .ic_busy (ic_busy),
    .i_rdata (i_rdata),
    .i_busy  (i_busy),
    .ic_addr (ic_addr),
    .ic_ren  (ic_ren)
  );

  dcache dcache_inst (
    .CLK     (CLK),
    .nRST    (nRST),
    .d_addr  (d_addr),
    .d_ren   (d_ren),
    .d_wen   (d_wen),
    .d_wdata (d_wdata),
    .dc_rdata(dc_rdata),
    .dc_busy (dc_busy),
    .d_rdata (d_rdata),
    .d_busy  (d_busy),
    .dc_addr (dc_addr),
    .dc_ren  (dc_ren),
    .dc_wen  (dc_wen),
    .dc_wdata(dc_wdata)
  );

  // single external bus, one transfer in flight
  memory_controller mc_inst (
    .CLK      (CLK),
    .nRST     (nRST),
    .ic_addr  (ic_addr),
    .ic_ren   (ic_ren),
    .dc_addr  (dc_addr),
    .dc_ren   (dc_ren),
    .dc_wen   (dc_wen),
    .dc_wdata (dc_wdata),
    .bus_rdata(bus_rdata),
    .bus_busy (bus_busy),
    .ic_rdata (ic_rdata),
    .ic_busy  (ic_busy),
    .dc_rdata (dc_rdata),
    .dc_busy  (dc_busy),
    .bus_addr (bus_addr),
    .bus_ren  (bus_ren),
    .bus_wen  (bus_wen),
    .bus_wdata(bus_wdata)
  );

endmodule

/* tb/bus_memory_model.sv */
/*
  word-addressed memory behind the external bus
  random response delay, bus read and write counters
*/
module bus_memory_model #(
  parameter logic [mem_sys_pkg::word_w-1:0] fill_base = 32'h1000_0000
) (
  input  logic                           CLK,
  input  logic                           nRST,
  input  logic [mem_sys_pkg::word_w-1:0] bus_addr,
  input  logic                           bus_ren,
  input  logic                           bus_wen,
  input  logic [mem_sys_pkg::word_w-1:0] bus_wdata,
  output logic [mem_sys_pkg::word_w-1:0] bus_rdata,
  output logic                           bus_busy,
  output logic [mem_sys_pkg::word_w-1:0] read_count,
  output logic [mem_sys_pkg::word_w-1:0] write_count
);

  // only written words live here and the rest reads the fill pattern
  logic [mem_sys_pkg::word_w-1:0] stored [logic [mem_sys_pkg::word_w-3:0]];

  logic [mem_sys_pkg::word_w-3:0] word_idx;
  logic                           active;
  logic [1:0]                     wait_left;
  logic                           done;

  assign word_idx = bus_addr[mem_sys_pkg::word_w-1:2];
  // completing cycle of the transfer with busy low
  assign done     = active && (wait_left == 2'd0);
  assign bus_busy = (bus_ren || bus_wen) && !done;

  // word n holds n*4 plus the base until written
  function automatic logic [mem_sys_pkg::word_w-1:0] lookup(
    input logic [mem_sys_pkg::word_w-3:0] w
  );
    if (stored.exists(w)) begin
      return stored[w];
    end
    return {w, 2'b00} + fill_base;
  endfunction

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      active      <= 1'b0;
      wait_left   <= 2'd0;
      bus_rdata   <= '0;
      read_count  <= '0;
      write_count <= '0;
    end else if (bus_ren || bus_wen) begin
      if (!active) begin
        // new request picks 1 to 4 busy cycles and latches the word
        active    <= 1'b1;
        wait_left <= 2'($urandom());
        bus_rdata <= lookup(word_idx);
      end else if (done) begin
        active <= 1'b0;
        if (bus_wen) begin
          write_count <= write_count + 1;
        end else begin
          read_count <= read_count + 1;
        end
      end else begin
        wait_left <= wait_left - 2'd1;
      end
    end
  end

  // write lands on the completing edge
  always @(posedge CLK) begin
    if (bus_wen && done) begin
      stored[word_idx] = bus_wdata;
    end
  end

endmodule

/* tb/tb_core_mem_top.sv */
/*
  testbench for core_mem_top, table of requests applied in a loop
  bus memory model on the external bus, cycle timeout
*/
module tb_core_mem_top;

  typedef enum logic [2:0] {
    op_idle,
    op_ifetch,
    op_dread,
    op_dwrite,
    op_both,
    op_halt,
    op_halt_fetch
  } op_t;

  // addr2 and exp2 belong to the fetch side of op_both
  typedef struct packed {
    op_t                            op;
    logic [mem_sys_pkg::word_w-1:0] addr;
    logic [mem_sys_pkg::word_w-1:0] addr2;
    logic [mem_sys_pkg::word_w-1:0] wdata;
    logic [mem_sys_pkg::word_w-1:0] exp;
    logic [mem_sys_pkg::word_w-1:0] exp2;
    logic [mem_sys_pkg::word_w-1:0] rd_delta;
    logic [mem_sys_pkg::word_w-1:0] wr_delta;
  } row_t;

  localparam logic [mem_sys_pkg::word_w-1:0] fill_base = 32'h1000_0000;

  logic CLK;
  logic nRST;
  logic halt_req;
  logic halt;
  logic i_ren;
  logic i_busy;
  logic d_ren;
  logic d_wen;
  logic d_busy;
  logic bus_ren;
  logic bus_wen;
  logic bus_busy;
  logic [mem_sys_pkg::word_w-1:0] i_addr;
  logic [mem_sys_pkg::word_w-1:0] i_rdata;
  logic [mem_sys_pkg::word_w-1:0] d_addr;
  logic [mem_sys_pkg::word_w-1:0] d_wdata;
  logic [mem_sys_pkg::word_w-1:0] d_rdata;
  logic [mem_sys_pkg::word_w-1:0] bus_addr;
  logic [mem_sys_pkg::word_w-1:0] bus_wdata;
  logic [mem_sys_pkg::word_w-1:0] bus_rdata;
  logic [mem_sys_pkg::word_w-1:0] read_count;
  logic [mem_sys_pkg::word_w-1:0] write_count;

  row_t rows[$];
  // completed bus transfers of the current row
  logic [mem_sys_pkg::word_w-1:0] rd_log[$];
  logic [mem_sys_pkg::word_w-1:0] wr_addr_log[$];
  logic [mem_sys_pkg::word_w-1:0] wr_data_log[$];
  int cycles = 0;
  int limit = 0;
  bit halted = 1'b0;

  core_mem_top core_mem_top_inst (
    .CLK(CLK), .nRST(nRST), .halt_req(halt_req),
    .i_addr(i_addr), .i_ren(i_ren), .d_addr(d_addr), .d_ren(d_ren), .d_wen(d_wen),
    .d_wdata(d_wdata), .bus_rdata(bus_rdata), .bus_busy(bus_busy), .halt(halt),
    .i_rdata(i_rdata), .i_busy(i_busy), .d_rdata(d_rdata), .d_busy(d_busy),
    .bus_addr(bus_addr), .bus_ren(bus_ren), .bus_wen(bus_wen), .bus_wdata(bus_wdata)
  );

  bus_memory_model #(.fill_base(fill_base)) memory_inst (
    .CLK(CLK), .nRST(nRST), .bus_addr(bus_addr), .bus_ren(bus_ren),
    .bus_wen(bus_wen), .bus_wdata(bus_wdata), .bus_rdata(bus_rdata),
    .bus_busy(bus_busy), .read_count(read_count), .write_count(write_count)
  );

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  // transfer completes in the one cycle with busy low
  always @(negedge CLK) begin
    if (bus_ren && !bus_busy) begin
      rd_log.push_back(bus_addr);
    end
    if (bus_wen && !bus_busy) begin
      wr_addr_log.push_back(bus_addr);
      wr_data_log.push_back(bus_wdata);
    end
  end

  always @(posedge CLK) begin
    cycles = cycles + 1;
    if (limit != 0 && cycles >= limit) begin
      abort_run($sformatf("timeout, run still going after %0d cycles", cycles));
    end
  end

  // memory word n holds n*4 plus the base
  function automatic logic [mem_sys_pkg::word_w-1:0] preload_word(
    input logic [mem_sys_pkg::word_w-1:0] a
  );
    return {a[mem_sys_pkg::word_w-1:2], 2'b00} + fill_base;
  endfunction

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("Errors found");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic expect_true(input bit ok, input string what);
    assert (ok) else abort_run($sformatf("Fail %0t: %s", $time, what));
  endtask

  task automatic expect_value(input logic [mem_sys_pkg::word_w-1:0] got,
                              input logic [mem_sys_pkg::word_w-1:0] want,
                              input string what);
    assert (got === want) else begin
      abort_run($sformatf("Fail %0t: %s is %h, expected %h", $time, what, got, want));
    end
  endtask

  task automatic add_row(input op_t op, input logic [mem_sys_pkg::word_w-1:0] addr,
                         input logic [mem_sys_pkg::word_w-1:0] addr2,
                         input logic [mem_sys_pkg::word_w-1:0] wdata,
                         input logic [mem_sys_pkg::word_w-1:0] exp,
                         input logic [mem_sys_pkg::word_w-1:0] exp2,
                         input logic [mem_sys_pkg::word_w-1:0] rd_delta,
                         input logic [mem_sys_pkg::word_w-1:0] wr_delta);
    row_t r;
    r.op = op;
    r.addr = addr;
    r.addr2 = addr2;
    r.wdata = wdata;
    r.exp = exp;
    r.exp2 = exp2;
    r.rd_delta = rd_delta;
    r.wr_delta = wr_delta;
    rows.push_back(r);
  endtask

  // one request on the fetch or data port held until busy drops
  task automatic single_transfer(input row_t r, output logic [mem_sys_pkg::word_w-1:0] got);
    @(posedge CLK);
    if (r.op == op_ifetch) begin
      i_addr <= r.addr;
      i_ren  <= 1'b1;
    end else begin
      d_addr  <= r.addr;
      d_wdata <= r.wdata;
      d_ren   <= (r.op == op_dread);
      d_wen   <= (r.op == op_dwrite);
    end
    @(negedge CLK);
    while ((r.op == op_ifetch) ? i_busy : d_busy) begin
      @(negedge CLK);
    end
    got = (r.op == op_ifetch) ? i_rdata : d_rdata;
    @(posedge CLK);
    i_ren <= 1'b0;
    d_ren <= 1'b0;
    d_wen <= 1'b0;
  endtask

  // fetch miss and data miss raised in the same cycle
  task automatic dual_transfer(input row_t r, output logic [mem_sys_pkg::word_w-1:0] got_i,
                               output logic [mem_sys_pkg::word_w-1:0] got_d);
    bit i_done;
    bit d_done;
    i_done = 1'b0;
    d_done = 1'b0;
    @(posedge CLK);
    i_addr <= r.addr2;
    i_ren  <= 1'b1;
    d_addr <= r.addr;
    d_ren  <= 1'b1;
    while (!(i_done && d_done)) begin
      @(negedge CLK);
      if (!i_done && !i_busy) begin
        got_i  = i_rdata;
        i_done = 1'b1;
      end
      if (!d_done && !d_busy) begin
        got_d  = d_rdata;
        d_done = 1'b1;
      end
      @(posedge CLK);
      if (i_done) begin
        i_ren <= 1'b0;
      end
      if (d_done) begin
        d_ren <= 1'b0;
      end
    end
  endtask

  task automatic pulse_halt();
    @(posedge CLK);
    halt_req <= 1'b1;
    @(posedge CLK);
    halt_req <= 1'b0;
    @(negedge CLK);
    expect_true(halt, "halt not set after halt_req");
  endtask

  // fetch stays stalled for ten cycles once halted
  task automatic halted_fetch(input row_t r);
    @(posedge CLK);
    i_addr <= r.addr;
    i_ren  <= 1'b1;
    repeat (10) begin
      @(negedge CLK);
      expect_true(i_busy, "i_busy low while halted");
    end
    @(posedge CLK);
    i_ren <= 1'b0;
  endtask

  initial begin
    row_t r;
    logic [mem_sys_pkg::word_w-1:0] got;
    logic [mem_sys_pkg::word_w-1:0] got_i;
    logic [mem_sys_pkg::word_w-1:0] rd_before;
    logic [mem_sys_pkg::word_w-1:0] wr_before;
    void'($urandom(28));
    nRST = 1'b0;
    halt_req = 1'b0;
    i_addr = '0;
    i_ren = 1'b0;
    d_addr = '0;
    d_ren = 1'b0;
    d_wen = 1'b0;
    d_wdata = '0;

    add_row(op_idle, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'd0, 32'd0);
    // fetch miss, hit, eviction by a same-index line, refetch
    add_row(op_ifetch, 32'h100, 32'h0, 32'h0, preload_word(32'h100), 32'h0, 32'd1, 32'd0);
    add_row(op_ifetch, 32'h100, 32'h0, 32'h0, preload_word(32'h100), 32'h0, 32'd0, 32'd0);
    add_row(op_ifetch, 32'h120, 32'h0, 32'h0, preload_word(32'h120), 32'h0, 32'd1, 32'd0);
    add_row(op_ifetch, 32'h100, 32'h0, 32'h0, preload_word(32'h100), 32'h0, 32'd1, 32'd0);
    // write miss stays uncached, write hit updates the line
    add_row(op_dwrite, 32'h200, 32'h0, 32'hcafe_0001, 32'h0, 32'h0, 32'd0, 32'd1);
    add_row(op_dread, 32'h200, 32'h0, 32'h0, 32'hcafe_0001, 32'h0, 32'd1, 32'd0);
    add_row(op_dwrite, 32'h200, 32'h0, 32'h5a5a_1234, 32'h0, 32'h0, 32'd0, 32'd1);
    add_row(op_dread, 32'h200, 32'h0, 32'h0, 32'h5a5a_1234, 32'h0, 32'd0, 32'd0);
    // data miss and fetch miss together
    add_row(op_both, 32'h400, 32'h504, 32'h0, preload_word(32'h400), preload_word(32'h504),
            32'd2, 32'd0);
    // data side keeps working on a halted core
    add_row(op_halt, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'd0, 32'd0);
    add_row(op_halt_fetch, 32'h700, 32'h0, 32'h0, 32'h0, 32'h0, 32'd0, 32'd0);
    add_row(op_halt_fetch, 32'h100, 32'h0, 32'h0, 32'h0, 32'h0, 32'd0, 32'd0);
    add_row(op_dwrite, 32'h240, 32'h0, 32'h0bad_f00d, 32'h0, 32'h0, 32'd0, 32'd1);
    add_row(op_dread, 32'h240, 32'h0, 32'h0, 32'h0bad_f00d, 32'h0, 32'd1, 32'd0);
    add_row(op_dwrite, 32'h240, 32'h0, 32'h1234_5678, 32'h0, 32'h0, 32'd0, 32'd1);
    add_row(op_dread, 32'h240, 32'h0, 32'h0, 32'h1234_5678, 32'h0, 32'd0, 32'd0);
    limit = rows.size() * 20;

    repeat (2) @(posedge CLK);
    nRST <= 1'b1;

    for (int n = 0; n < rows.size(); n++) begin
      r = rows[n];
      rd_before = read_count;
      wr_before = write_count;
      rd_log.delete();
      wr_addr_log.delete();
      wr_data_log.delete();
      case (r.op)
        op_idle: begin
          @(negedge CLK);
          expect_true(!bus_ren && !bus_wen, "bus request active with no request");
          expect_true(!i_busy && !d_busy, "busy high with no request");
        end
        op_ifetch, op_dread, op_dwrite: begin
          single_transfer(r, got);
          if (r.op != op_dwrite) begin
            expect_value(got, r.exp, $sformatf("row %0d rdata", n));
          end
        end
        op_both: begin
          dual_transfer(r, got_i, got);
          expect_value(got, r.exp, $sformatf("row %0d d_rdata", n));
          expect_value(got_i, r.exp2, $sformatf("row %0d i_rdata", n));
          expect_true(rd_log.size() == 2, "arbitration row did not log two reads");
          expect_value(rd_log[0], r.addr, "first bus read address");
          expect_value(rd_log[1], r.addr2, "second bus read address");
        end
        op_halt: begin
          pulse_halt();
          halted = 1'b1;
        end
        default: halted_fetch(r);
      endcase
      @(negedge CLK);
      expect_true(halt == halted, $sformatf("row %0d halt level wrong", n));
      expect_value(read_count - rd_before, r.rd_delta, $sformatf("row %0d bus reads", n));
      expect_value(write_count - wr_before, r.wr_delta, $sformatf("row %0d bus writes", n));
      if (r.op == op_dwrite) begin
        expect_true(wr_addr_log.size() == 1, "write row did not log one bus write");
        expect_value(wr_addr_log[0], r.addr, "bus write address");
        expect_value(wr_data_log[0], r.wdata, "bus write data");
      end
    end

    $display("No errors");
    $finish;
  end

endmodule

/* verilog.f */
logic/mem_sys_pkg.sv
logic/icache.sv
logic/dcache.sv
logic/memory_controller.sv
logic/core_mem_top.sv
tb/bus_memory_model.sv
tb/tb_core_mem_top.sv

/* Makefile */
# Verilator build and run of the memory side testbench

VERILATOR ?= verilator
TOP       ?= tb_core_mem_top
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
JOBS      ?= 4

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run $(TOP)"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS JOBS"

test:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
